/* src/bif_dpath_cfg.svh */
`ifndef BIF_DPATH_CFG_SVH
`define BIF_DPATH_CFG_SVH

////////////////////////////////////////////////////////////
// Bus geometry
////////////////////////////////////////////////////////////

// Both the local data bus and the CPU data bus are one word wide.
`define BIF_BUS_WIDTH 16

////////////////////////////////////////////////////////////
// Idle bus level
////////////////////////////////////////////////////////////

// A bus nobody drives floats to the pull-up level.
`define BIF_RELEASED_WORD {`BIF_BUS_WIDTH{1'b1}}

`endif

/* src/bif_dpath_pkg.sv */
`default_nettype none

`include "bif_dpath_cfg.svh"

package bif_dpath_pkg;

   ////////////////////////////////////////////////////////////
   // Data words
   ////////////////////////////////////////////////////////////

   // One word on the LBD or the CD.
   typedef logic [`BIF_BUS_WIDTH-1:0] bus_word_t;

   ////////////////////////////////////////////////////////////
   // Control levels from the bus interface sequencer
   ////////////////////////////////////////////////////////////

   typedef struct packed {
      logic dstb_n; // LBD data strobe. Low passes live data.
      logic ecreq;  // CD capture request. Rising edge stores CD.
      logic emd_n;  // Output enable for both buses.
      logic wlbd_n; // Direction. Low drives the LBD.
   } bus_ctl_t;

   ////////////////////////////////////////////////////////////
   // One bus output with its enable
   ////////////////////////////////////////////////////////////

   typedef struct packed {
      bus_word_t data; // Word placed on the bus.
      logic      oe;   // High while this side drives the bus.
   } bus_drive_t;

endpackage

`default_nettype wire

/* src/bif_lbd_capture.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bif_dpath_cfg.svh"

// LBD to CD register. The A side latch of the transceiver pair.
module bif_lbd_capture (
   input  logic                     clk,
   input  logic                     reset,
   input  bif_dpath_pkg::bus_word_t lbd_in,   // Live LBD word.
   input  logic                     dstb_n,   // Data strobe level.
   output bif_dpath_pkg::bus_word_t a2b_word  // Word heading for the CD.
);

   ////////////////////////////////////////////////////////////
   // Strobe edge detect
   ////////////////////////////////////////////////////////////

   logic                     dstb_n_q;  // Strobe as seen last clock.
   logic                     dstb_rise; // Strobe went low to high.
   bif_dpath_pkg::bus_word_t held_word; // Word caught at the edge.

   assign dstb_rise = dstb_n & ~dstb_n_q; // High now and low before.

   ////////////////////////////////////////////////////////////
   // Capture register
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         dstb_n_q  <= 1'b1;         // Idle high so no false edge.
         held_word <= '0;           // Empty register.
      end else begin
         dstb_n_q <= dstb_n;        // Track the strobe.
         if (dstb_rise) begin
            held_word <= lbd_in;    // Latch the word at the edge.
         end
      end
   end

   // Source select follows the strobe.
   // Low strobe is transparent and high strobe shows stored data.
   assign a2b_word = dstb_n ? held_word : lbd_in;

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   // Stored word only moves on a clock that saw a strobe edge.
   held_word_on_edge_only : assert property (
      @(posedge clk) disable iff (reset)
      (!$past(reset) && !$past(dstb_rise)) |-> $stable(held_word)
   ) else $error("held LBD word changed without a dstb_n rising edge");

endmodule

`default_nettype wire

/* src/bif_cd_capture.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bif_dpath_cfg.svh"

// CD to LBD register. The B side latch of the transceiver pair.
module bif_cd_capture (
   input  logic                     clk,
   input  logic                     reset,
   input  bif_dpath_pkg::bus_word_t cd_in,    // Live CD word.
   input  logic                     ecreq,    // Capture request level.
   output bif_dpath_pkg::bus_word_t b2a_word  // Word heading for the LBD.
);

   ////////////////////////////////////////////////////////////
   // Request edge detect
   ////////////////////////////////////////////////////////////

   logic                     ecreq_q;    // Request as seen last clock.
   logic                     ecreq_rise; // Request went low to high.
   bif_dpath_pkg::bus_word_t held_word;  // Word caught at the edge.

   assign ecreq_rise = ecreq & ~ecreq_q; // High now and low before.

   ////////////////////////////////////////////////////////////
   // Capture register
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         ecreq_q   <= 1'b1;         // Treat as high so no false edge.
         held_word <= '0;           // Empty register.
      end else begin
         ecreq_q <= ecreq;          // Track the request.
         if (ecreq_rise) begin
            held_word <= cd_in;     // Latch the CD word.
         end
      end
   end

   // The LBD side always reads stored data, never the live CD.
   assign b2a_word = held_word;

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   // Returned word holds still unless the clock before saw a request edge.
   b2a_stable_without_edge : assert property (
      @(posedge clk) disable iff (reset)
      (!$past(reset) && !$past(ecreq_rise)) |-> $stable(b2a_word)
   ) else $error("b2a_word changed without an ecreq rising edge");

endmodule

`default_nettype wire

/* src/bif_bus_drive.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bif_dpath_cfg.svh"

// Output stage. Picks the driven bus and registers both sides.
module bif_bus_drive (
   input  logic                      clk,
   input  logic                      reset,
   input  bif_dpath_pkg::bus_word_t  a2b_word, // From the LBD capture.
   input  bif_dpath_pkg::bus_word_t  b2a_word, // From the CD capture.
   input  logic                      emd_n,    // Output enable. Low enables.
   input  logic                      wlbd_n,   // Direction. Low drives LBD.
   output bif_dpath_pkg::bus_drive_t lbd_out,  // Registered LBD side.
   output bif_dpath_pkg::bus_drive_t cd_out    // Registered CD side.
);

   // Value of a side that is not driving.
   localparam bif_dpath_pkg::bus_drive_t released_drive = '{
      data: `BIF_RELEASED_WORD,
      oe:   1'b0
   };

   ////////////////////////////////////////////////////////////
   // Direction and enable decode
   ////////////////////////////////////////////////////////////

   logic                      drive_cd;  // CD side owns the bus.
   logic                      drive_lbd; // LBD side owns the bus.
   bif_dpath_pkg::bus_drive_t lbd_next;  // Next LBD output.
   bif_dpath_pkg::bus_drive_t cd_next;   // Next CD output.

   assign drive_cd  = ~emd_n &  wlbd_n; // Enabled and pointing at CD.
   assign drive_lbd = ~emd_n & ~wlbd_n; // Enabled and pointing at LBD.

   always_comb begin
      lbd_next = released_drive;     // Default is pulled high.
      cd_next  = released_drive;
      if (drive_cd) begin
         cd_next.data = a2b_word;    // LBD data out on the CD.
         cd_next.oe   = 1'b1;
      end
      if (drive_lbd) begin
         lbd_next.data = b2a_word;   // Stored CD data back on the LBD.
         lbd_next.oe   = 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////
   // Output registers
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         lbd_out <= released_drive; // Both buses float after reset.
         cd_out  <= released_drive;
      end else begin
         lbd_out <= lbd_next;       // One clock of latency.
         cd_out  <= cd_next;
      end
   end

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   // Never drive both sides in the same cycle.
   no_double_drive : assert property (
      @(posedge clk) disable iff (reset)
      !(lbd_out.oe && cd_out.oe)
   ) else $error("LBD and CD driven together");

   // A released side reads as the pull-up level.
   lbd_released_high : assert property (
      @(posedge clk) disable iff (reset)
      !lbd_out.oe |-> (lbd_out.data == `BIF_RELEASED_WORD)
   ) else $error("released LBD does not read all ones");

   cd_released_high : assert property (
      @(posedge clk) disable iff (reset)
      !cd_out.oe |-> (cd_out.data == `BIF_RELEASED_WORD)
   ) else $error("released CD does not read all ones");

endmodule

`default_nettype wire

/* src/bif_dpath_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bif_dpath_cfg.svh"

// CPU bus interface data path between the LBD and the CD.
module bif_dpath_top (
   input  logic                      clk,
   input  logic                      reset,
   input  bif_dpath_pkg::bus_word_t  lbd_in,  // Local data bus input.
   input  bif_dpath_pkg::bus_word_t  cd_in,   // CPU data bus input.
   input  bif_dpath_pkg::bus_ctl_t   ctl,     // Strobes and bus controls.
   output bif_dpath_pkg::bus_drive_t lbd_out, // Local data bus output.
   output bif_dpath_pkg::bus_drive_t cd_out   // CPU data bus output.
);

   ////////////////////////////////////////////////////////////
   // Internal words
   ////////////////////////////////////////////////////////////

   bif_dpath_pkg::bus_word_t a2b_word; // LBD word toward the CD.
   bif_dpath_pkg::bus_word_t b2a_word; // Stored CD word toward the LBD.

   ////////////////////////////////////////////////////////////
   // LBD to CD capture
   ////////////////////////////////////////////////////////////

   bif_lbd_capture u_lbd_capture (
      .clk      (clk),
      .reset    (reset),
      .lbd_in   (lbd_in),
      .dstb_n   (ctl.dstb_n),     // Strobe clocks and selects.
      .a2b_word (a2b_word)
   );

   ////////////////////////////////////////////////////////////
   // CD to LBD capture
   ////////////////////////////////////////////////////////////

   bif_cd_capture u_cd_capture (
      .clk      (clk),
      .reset    (reset),
      .cd_in    (cd_in),
      .ecreq    (ctl.ecreq),      // Request edge stores CD.
      .b2a_word (b2a_word)
   );

   ////////////////////////////////////////////////////////////
   // Bus drivers
   ////////////////////////////////////////////////////////////

   bif_bus_drive u_bus_drive (
      .clk      (clk),
      .reset    (reset),
      .a2b_word (a2b_word),
      .b2a_word (b2a_word),
      .emd_n    (ctl.emd_n),      // Shared output enable.
      .wlbd_n   (ctl.wlbd_n),     // Shared direction.
      .lbd_out  (lbd_out),
      .cd_out   (cd_out)
   );

endmodule

`default_nettype wire

/* sim/bif_dpath_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bif_dpath_cfg.svh"

module bif_dpath_tb;

   typedef struct packed {
      bif_dpath_pkg::bus_drive_t lbd; // Expected LBD side.
      bif_dpath_pkg::bus_drive_t cd;  // Expected CD side.
   } drive_pair_t;

   localparam bif_dpath_pkg::bus_drive_t released = '{
      data: `BIF_RELEASED_WORD,
      oe:   1'b0
   };

   logic                      clk;
   logic                      reset;
   bif_dpath_pkg::bus_word_t  lbd_in;
   bif_dpath_pkg::bus_word_t  cd_in;
   bif_dpath_pkg::bus_ctl_t   ctl;
   bif_dpath_pkg::bus_drive_t lbd_out;
   bif_dpath_pkg::bus_drive_t cd_out;

   logic [31:0]              rng_state;          // Xorshift state.
   bif_dpath_pkg::bus_word_t held_lbd_ref;       // Model copy of the LBD register.
   bif_dpath_pkg::bus_word_t held_cd_ref;        // Model copy of the CD register.
   logic                     dstb_ref_q;         // Model strobe history.
   logic                     ecreq_ref_q;        // Model request history.
   drive_pair_t              expected;           // Prediction for the next edge.
   logic                     pred_valid = 1'b0;  // No prediction before the first edge.
   string                    test_name = "";
   int                       test_errors = 0;
   int                       pass_count = 0;
   int                       fail_count = 0;

   bif_dpath_top UUT (
      .clk     (clk),
      .reset   (reset),
      .lbd_in  (lbd_in),
      .cd_in   (cd_in),
      .ctl     (ctl),
      .lbd_out (lbd_out),
      .cd_out  (cd_out)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;  // 4 ns period.
   end

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // Expected outputs after the coming edge, from the inputs seen at that edge.
   function automatic drive_pair_t bif_model(
      input logic                     rst,
      input bif_dpath_pkg::bus_word_t lbd,
      input bif_dpath_pkg::bus_word_t cd,
      input bif_dpath_pkg::bus_ctl_t  c
   );
      drive_pair_t              res;
      bif_dpath_pkg::bus_word_t a2b;
      res.lbd = released;                         // Released unless selected.
      res.cd  = released;
      if (rst) begin
         held_lbd_ref = '0;
         held_cd_ref  = '0;
         dstb_ref_q   = 1'b1;                      // Idle high, no false edge.
         ecreq_ref_q  = 1'b1;
      end else begin
         a2b = c.dstb_n ? held_lbd_ref : lbd;      // Old held word on the edge clock.
         if (!c.emd_n && c.wlbd_n) begin
            res.cd.data = a2b;
            res.cd.oe   = 1'b1;
         end
         if (!c.emd_n && !c.wlbd_n) begin
            res.lbd.data = held_cd_ref;
            res.lbd.oe   = 1'b1;
         end
         if (c.dstb_n && !dstb_ref_q) held_lbd_ref = lbd;
         if (c.ecreq && !ecreq_ref_q) held_cd_ref = cd;
         dstb_ref_q  = c.dstb_n;
         ecreq_ref_q = c.ecreq;
      end
      return res;
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #1;                                          // Drive and sample clear of the edge.
   endtask

   task automatic check_drive(
      input string                     what,
      input bif_dpath_pkg::bus_drive_t exp_drive,
      input bif_dpath_pkg::bus_drive_t act_drive
   );
      if (act_drive !== exp_drive) begin
         $display("** Error %s: %s expected data=%h oe=%b, actual data=%h oe=%b",
                  test_name, what, exp_drive.data, exp_drive.oe,
                  act_drive.data, act_drive.oe);
         test_errors++;
      end
   endtask

   task automatic check_bit(input string what, input logic exp_bit, input logic act_bit);
      if (act_bit !== exp_bit) begin
         $display("** Error %s: %s expected %b, actual %b", test_name, what, exp_bit, act_bit);
         test_errors++;
      end
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      test_errors = 0;
   endtask

   task automatic close_test();
      if (test_errors == 0) begin
         $display("%s: ok", test_name);
         pass_count++;
      end else begin
         $display("%s: FAILED with %0d errors", test_name, test_errors);
         fail_count++;
      end
   endtask

   // Waits for the LBD to carry a word, bounded by limit clocks.
   task automatic wait_lbd_word(
      input  bif_dpath_pkg::bus_word_t word,
      input  int                       limit,
      output int                       clocks,
      output logic                     found
   );
      clocks = 0;
      found  = 1'b0;
      while (!found && clocks < limit) begin
         next_cycle();
         clocks++;
         found = (lbd_out.oe === 1'b1) && (lbd_out.data === word);
      end
      if (!found) begin
         $display("%s: timed out after %0d clocks waiting for the LBD to carry %h",
                  test_name, limit, word);
         test_errors++;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Compare process
   ////////////////////////////////////////////////////////////

   always @(posedge clk) begin
      if (pred_valid) begin
         check_drive("lbd_out", expected.lbd, lbd_out); // Registered at the last edge.
         check_drive("cd_out", expected.cd, cd_out);
      end
      expected   = bif_model(reset, lbd_in, cd_in, ctl);
      pred_valid = 1'b1;
   end

   ////////////////////////////////////////////////////////////
   // Tests
   ////////////////////////////////////////////////////////////

   task automatic reset_idle();
      start_test("reset_idle");
      repeat (16) begin
         next_cycle();
         check_drive("lbd_out in reset", released, lbd_out);
         check_drive("cd_out in reset", released, cd_out);
      end
      reset = 1'b0;
      next_cycle();
      check_drive("lbd_out after reset", released, lbd_out);
      check_drive("cd_out after reset", released, cd_out);
      close_test();
   endtask

   task automatic lbd_live();
      logic [31:0]               r;
      bif_dpath_pkg::bus_drive_t exp_drive;
      start_test("lbd_live");
      ctl = '{dstb_n: 1'b0, ecreq: 1'b0, emd_n: 1'b0, wlbd_n: 1'b1};
      exp_drive.oe = 1'b1;
      repeat (32) begin
         r              = next_rand();
         lbd_in         = r[`BIF_BUS_WIDTH-1:0];
         exp_drive.data = lbd_in;                  // Passes straight through.
         next_cycle();
         check_drive("cd_out", exp_drive, cd_out);
      end
      close_test();
   endtask

   task automatic lbd_held();
      logic [31:0]               r;
      bif_dpath_pkg::bus_drive_t exp_drive;
      start_test("lbd_held");
      ctl = '{dstb_n: 1'b0, ecreq: 1'b0, emd_n: 1'b0, wlbd_n: 1'b1};
      next_cycle();                                // Strobe low before each edge.
      repeat (4) begin
         r          = next_rand();
         lbd_in     = r[`BIF_BUS_WIDTH-1:0];
         ctl.dstb_n = 1'b1;                        // Rising edge.
         exp_drive  = '{data: lbd_in, oe: 1'b1};
         next_cycle();                             // Edge clock, old word leaves.
         repeat (6) begin
            r      = next_rand();
            lbd_in = r[`BIF_BUS_WIDTH-1:0];        // Ignored while held.
            next_cycle();
            check_drive("cd_out held", exp_drive, cd_out);
         end
         r          = next_rand();
         lbd_in     = r[`BIF_BUS_WIDTH-1:0];
         ctl.dstb_n = 1'b0;                        // Falling edge, live again.
         exp_drive.data = lbd_in;
         next_cycle();
         check_drive("cd_out live", exp_drive, cd_out);
      end
      close_test();
   endtask

   task automatic cd_held();
      logic [31:0]               r;
      bif_dpath_pkg::bus_word_t  last_word;
      bif_dpath_pkg::bus_drive_t exp_drive;
      int                        clocks;
      int                        gap;
      logic                      found;
      start_test("cd_held");
      ctl = '{dstb_n: 1'b0, ecreq: 1'b0, emd_n: 1'b0, wlbd_n: 1'b0};
      next_cycle();
      last_word = lbd_out.data;                    // Word stored before this test.
      repeat (6) begin
         r     = next_rand();
         cd_in = r[`BIF_BUS_WIDTH-1:0];
         if (cd_in == last_word) cd_in = ~cd_in;   // Make the capture visible.
         exp_drive = '{data: cd_in, oe: 1'b1};
         ctl.ecreq = 1'b1;                         // Request rises.
         wait_lbd_word(exp_drive.data, 6, clocks, found);
         if (found && clocks != 2) begin
            $display("** Error %s: capture latency expected 2, actual %0d",
                     test_name, clocks);
            test_errors++;
         end
         ctl.ecreq = 1'b0;
         gap       = 2 + (r[31:28] % 4);           // Random gap between pulses.
         repeat (gap) begin
            r     = next_rand();
            cd_in = r[`BIF_BUS_WIDTH-1:0];         // Not captured without an edge.
            next_cycle();
            check_drive("lbd_out held", exp_drive, lbd_out);
         end
         last_word = exp_drive.data;
      end
      close_test();
   endtask

   task automatic release_and_direction();
      logic [31:0] r;
      logic        emd_n_q;
      logic        wlbd_n_q;
      start_test("release_and_direction");
      repeat (200) begin
         r        = next_rand();
         lbd_in   = r[`BIF_BUS_WIDTH-1:0];
         r        = next_rand();
         cd_in    = r[`BIF_BUS_WIDTH-1:0];
         ctl      = bif_dpath_pkg::bus_ctl_t'(r[31:28]);
         emd_n_q  = ctl.emd_n;
         wlbd_n_q = ctl.wlbd_n;
         next_cycle();
         if (emd_n_q) begin                        // Both buses float.
            check_drive("lbd_out released", released, lbd_out);
            check_drive("cd_out released", released, cd_out);
         end else begin                            // Exactly one side drives.
            check_bit("cd_out.oe", wlbd_n_q, cd_out.oe);
            check_bit("lbd_out.oe", ~wlbd_n_q, lbd_out.oe);
         end
      end
      close_test();
   endtask

   task automatic random_mix();
      logic [31:0] r;
      start_test("random_mix");
      repeat (2000) begin
         r      = next_rand();
         lbd_in = r[`BIF_BUS_WIDTH-1:0];
         ctl    = bif_dpath_pkg::bus_ctl_t'(r[31:28]);
         r      = next_rand();
         cd_in  = r[`BIF_BUS_WIDTH-1:0];
         next_cycle();                             // Compare process checks each edge.
      end
      next_cycle();                                // Last prediction gets checked.
      close_test();
   endtask

   ////////////////////////////////////////////////////////////
   // Sequence
   ////////////////////////////////////////////////////////////

   initial begin
      rng_state = 32'hd61fef57;
      reset     = 1'b1;
      lbd_in    = '0;
      cd_in     = '0;
      ctl       = '{dstb_n: 1'b1, ecreq: 1'b0, emd_n: 1'b1, wlbd_n: 1'b1};
      reset_idle();
      lbd_live();
      lbd_held();
      cd_held();
      release_and_direction();
      random_mix();
      $display("passing tests: %0d, failing tests: %0d", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* compile.f */
+incdir+src
src/bif_dpath_pkg.sv
src/bif_lbd_capture.sv
src/bif_cd_capture.sv
src/bif_bus_drive.sv
src/bif_dpath_top.sv
sim/bif_dpath_tb.sv

/* Bender.yml */
package:
  name: bif_dpath

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/bif_dpath_pkg.sv
      - src/bif_lbd_capture.sv
      - src/bif_cd_capture.sv
      - src/bif_bus_drive.sv
      - src/bif_dpath_top.sv

  - target: simulation
    include_dirs:
      - src
    files:
      - sim/bif_dpath_tb.sv
